// File: rf_core_pkg.sv
//--------------------
// Shared definitions for the RV32 register-file subsystem
// Sizes, instruction encodings and the decoded instruction word
//--------------------

`default_nettype none

package rf_core_pkg;

  //--------------------
  // Register file sizes
  //--------------------
  localparam int DATA_WIDTH              = 32;
  localparam int REGFILE_NUM_WORDS       = 32;
  localparam int REGFILE_NUM_READ_PORTS  = 2;
  // Port 0 is ALU writeback, port 1 is load return
  localparam int REGFILE_NUM_WRITE_PORTS = 2;

  // Register index, x0 to x31
  typedef logic [4:0] regfile_addr_t;

  //--------------------
  // Major opcodes
  //--------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  // Function codes shared by R-type and I-type
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  // funct7 picks ADD or SUB in R-type
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

  //--------------------
  // Instruction word, seen as R-type or I-type
  //--------------------
  typedef union packed {
    struct packed {
      logic [6:0]    funct7;
      regfile_addr_t rs2;
      regfile_addr_t rs1;
      logic [2:0]    funct3;
      regfile_addr_t rd;
      logic [6:0]    opcode;
    } r_fmt;
    struct packed {
      logic [11:0]   imm;
      regfile_addr_t rs1;
      logic [2:0]    funct3;
      regfile_addr_t rd;
      logic [6:0]    opcode;
    } i_fmt;
  } instr_u;

endpackage

`default_nettype wire

// File: rf_register_file.sv
//--------------------
// Integer register file built from flip-flops
// Two combinational read ports, two write ports
// x0 is hard-wired to zero
//--------------------

`timescale 1ns/1ns
`default_nettype none

module rf_register_file import rf_core_pkg::*; (
  input  wire logic          clk,
  input  wire logic          rst_n,

  // Read ports
  input  regfile_addr_t [REGFILE_NUM_READ_PORTS-1:0]                  raddr_i,
  output logic          [REGFILE_NUM_READ_PORTS-1:0][DATA_WIDTH-1:0]  rdata_o,

  // Write ports, the higher index wins on a collision
  input  regfile_addr_t [REGFILE_NUM_WRITE_PORTS-1:0]                 waddr_i,
  input  wire logic     [REGFILE_NUM_WRITE_PORTS-1:0][DATA_WIDTH-1:0] wdata_i,
  input  wire logic     [REGFILE_NUM_WRITE_PORTS-1:0]                 we_i
);

  // Register storage
  logic [DATA_WIDTH-1:0] mem [REGFILE_NUM_WORDS];

  // One-hot write enable per port and register
  logic [REGFILE_NUM_WRITE_PORTS-1:0][REGFILE_NUM_WORDS-1:0] we_dec;

  //--------------------
  // Read side
  //--------------------
  for (genvar rp = 0; rp < REGFILE_NUM_READ_PORTS; rp++) begin : gen_read
    assign rdata_o[rp] = mem[raddr_i[rp]];
  end

  //--------------------
  // Write address decode
  //--------------------
  for (genvar wp = 0; wp < REGFILE_NUM_WRITE_PORTS; wp++) begin : gen_wdec_port
    for (genvar r = 0; r < REGFILE_NUM_WORDS; r++) begin : gen_wdec_reg
      assign we_dec[wp][r] = we_i[wp] && (waddr_i[wp] == regfile_addr_t'(r));
    end
  end

  //--------------------
  // Register update
  //--------------------
  // x0 ignores every write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem[0] <= '0;
    end else begin
      mem[0] <= '0;
    end
  end

  for (genvar r = 1; r < REGFILE_NUM_WORDS; r++) begin : gen_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[r] <= '0;
      end else begin
        // Later ports overwrite earlier ones in this loop
        for (int p = 0; p < REGFILE_NUM_WRITE_PORTS; p++) begin
          if (we_dec[p][r]) begin
            mem[r] <= wdata_i[p];
          end
        end
      end
    end
  end

  // x0 reads back zero on every port, even right after a write to it
  for (genvar rp = 0; rp < REGFILE_NUM_READ_PORTS; rp++) begin : gen_x0_chk
    a_x0_zero : assert property (@(posedge clk) disable iff (!rst_n)
      (raddr_i[rp] == '0) |-> (rdata_o[rp] == '0));
  end

endmodule

`default_nettype wire

// File: rf_operand_fetch.sv
//--------------------
// Operand fetch stage
// Decodes R/I-type ALU instructions, reads both sources,
// forwards in-flight results and registers the operands
//--------------------

`timescale 1ns/1ns
`default_nettype none

module rf_operand_fetch import rf_core_pkg::*; (
  input  wire logic                                           clk,
  input  wire logic                                           rst_n,
  // Instruction in
  input  wire logic                                           instr_valid_i,
  input  instr_u                                              instr_i,
  // Register file read
  output regfile_addr_t [REGFILE_NUM_READ_PORTS-1:0]          raddr_o,
  input  wire logic [REGFILE_NUM_READ_PORTS-1:0][DATA_WIDTH-1:0] rdata_i,
  // Execute stage result, issued one cycle earlier
  input  wire logic                                           ex_valid_i,
  input  regfile_addr_t                                       ex_rd_i,
  input  wire logic [DATA_WIDTH-1:0]                          ex_result_i,
  // Writeback, issued two cycles earlier
  input  wire logic                                           wb_we_i,
  input  regfile_addr_t                                       wb_rd_i,
  input  wire logic [DATA_WIDTH-1:0]                          wb_data_i,
  // Load return lane
  input  wire logic                                           load_we_i,
  input  regfile_addr_t                                       load_waddr_i,
  input  wire logic [DATA_WIDTH-1:0]                          load_wdata_i,
  // Registered operands for execute
  output logic                                                op_valid_o,
  output regfile_addr_t                                       op_rd_o,
  output logic [2:0]                                          op_funct3_o,
  output logic                                                op_sub_o,
  output logic [DATA_WIDTH-1:0]                               op_a_o,
  output logic [DATA_WIDTH-1:0]                               op_b_o
);

  logic                  is_op;
  logic                  is_op_imm;
  logic                  funct3_ok;
  logic                  funct7_ok;
  logic                  dec_valid;
  logic                  dec_sub;
  regfile_addr_t         dec_rs1;
  regfile_addr_t         dec_rd;
  logic [2:0]            dec_funct3;
  logic [DATA_WIDTH-1:0] imm_sext;
  logic [DATA_WIDTH-1:0] fwd_a;
  logic [DATA_WIDTH-1:0] fwd_b;

  //--------------------
  // Decode
  //--------------------
  assign is_op     = (instr_i.r_fmt.opcode == OPCODE_OP);
  assign is_op_imm = (instr_i.i_fmt.opcode == OPCODE_OP_IMM);

  // rs1, funct3 and rd sit at the same bits in both formats
  assign dec_rs1    = instr_i.r_fmt.rs1;
  assign dec_rd     = instr_i.r_fmt.rd;
  assign dec_funct3 = instr_i.r_fmt.funct3;

  assign funct3_ok = (dec_funct3 == FUNCT3_ADD) || (dec_funct3 == FUNCT3_XOR) ||
                     (dec_funct3 == FUNCT3_OR)  || (dec_funct3 == FUNCT3_AND);
  // SUB only exists next to ADD
  assign funct7_ok = (instr_i.r_fmt.funct7 == FUNCT7_BASE) ||
                     ((instr_i.r_fmt.funct7 == FUNCT7_SUB) && (dec_funct3 == FUNCT3_ADD));

  // Anything else is dropped here
  assign dec_valid = instr_valid_i && funct3_ok && ((is_op && funct7_ok) || is_op_imm);
  assign dec_sub   = is_op && (instr_i.r_fmt.funct7 == FUNCT7_SUB);
  assign imm_sext  = {{(DATA_WIDTH-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};

  assign raddr_o[0] = dec_rs1;
  assign raddr_o[1] = instr_i.r_fmt.rs2;

  //--------------------
  // Forwarding
  //--------------------
  // Youngest producer first, then load over writeback
  // (same order as the register file ports)
  function automatic logic [DATA_WIDTH-1:0] fwd_sel(input regfile_addr_t addr,
                                                    input logic [DATA_WIDTH-1:0] rf_data);
    logic [DATA_WIDTH-1:0] sel;
    sel = rf_data;
    if (addr != '0) begin
      if (ex_valid_i && (ex_rd_i == addr)) begin
        sel = ex_result_i;
      end else if (load_we_i && (load_waddr_i == addr)) begin
        sel = load_wdata_i;
      end else if (wb_we_i && (wb_rd_i == addr)) begin
        sel = wb_data_i;
      end
    end
    return sel;
  endfunction

  assign fwd_a = fwd_sel(raddr_o[0], rdata_i[0]);
  assign fwd_b = fwd_sel(raddr_o[1], rdata_i[1]);

  //--------------------
  // Pipeline register
  //--------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid_o <= 1'b0;
    end else begin
      op_valid_o <= dec_valid;
    end
  end

  // Payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      op_rd_o     <= dec_rd;
      op_funct3_o <= dec_funct3;
      op_sub_o    <= dec_sub;
      op_a_o      <= fwd_a;
      op_b_o      <= is_op_imm ? imm_sext : fwd_b;
    end
  end

  a_op_valid_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(op_valid_o));

endmodule

`default_nettype wire

// File: rf_execute.sv
//--------------------
// Execute and writeback stage
// Reduced ALU, result register feeding write port 0
//--------------------

`timescale 1ns/1ns
`default_nettype none

module rf_execute import rf_core_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Operands from fetch
  input  wire logic                  op_valid_i,
  input  regfile_addr_t              op_rd_i,
  input  wire logic [2:0]            op_funct3_i,
  input  wire logic                  op_sub_i,
  input  wire logic [DATA_WIDTH-1:0] op_a_i,
  input  wire logic [DATA_WIDTH-1:0] op_b_i,
  // Combinational result, forwarded back to fetch
  output logic                       ex_valid_o,
  output regfile_addr_t              ex_rd_o,
  output logic [DATA_WIDTH-1:0]      ex_result_o,
  // Writeback register
  output logic                       wb_we_o,
  output regfile_addr_t              wb_rd_o,
  output logic [DATA_WIDTH-1:0]      wb_data_o
);

  logic [DATA_WIDTH-1:0] alu_result;
  logic [DATA_WIDTH-1:0] add_sub;

  //--------------------
  // ALU
  //--------------------
  // Subtract as a + ~b + 1
  assign add_sub = op_sub_i ? (op_a_i - op_b_i) : (op_a_i + op_b_i);

  always_comb begin
    case (op_funct3_i)
      FUNCT3_ADD: alu_result = add_sub;
      FUNCT3_XOR: alu_result = op_a_i ^ op_b_i;
      FUNCT3_OR:  alu_result = op_a_i | op_b_i;
      FUNCT3_AND: alu_result = op_a_i & op_b_i;
      // Fetch never issues other codes
      default:    alu_result = '0;
    endcase
  end

  // Visible to fetch in the same cycle
  assign ex_valid_o  = op_valid_i;
  assign ex_rd_o     = op_rd_i;
  assign ex_result_o = alu_result;

  //--------------------
  // Writeback
  //--------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_o <= 1'b0;
    end else begin
      wb_we_o <= op_valid_i;
    end
  end

  // Holds the last result between instructions
  always_ff @(posedge clk) begin
    if (op_valid_i) begin
      wb_rd_o   <= op_rd_i;
      wb_data_o <= alu_result;
    end
  end

  // Every writeback comes from an operand set one cycle earlier
  a_wb_from_op : assert property (@(posedge clk) disable iff (!rst_n)
    wb_we_o |-> $past(op_valid_i));

endmodule

`default_nettype wire

// File: rf_core_top.sv
//--------------------
// Register-file subsystem top level
// Operand fetch, register file and execute in a 2-cycle pipe
// Load-return lane drives write port 1
//--------------------

`timescale 1ns/1ns
`default_nettype none

module rf_core_top import rf_core_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Instruction input
  input  wire logic                  instr_valid_i,
  input  instr_u                     instr_i,
  // Load return, committed at the end of this cycle
  input  wire logic                  load_we_i,
  input  regfile_addr_t              load_waddr_i,
  input  wire logic [DATA_WIDTH-1:0] load_wdata_i,
  // Result, two cycles after issue
  output logic                       result_valid_o,
  output regfile_addr_t              result_rd_o,
  output logic [DATA_WIDTH-1:0]      result_o
);

  // Register file read path
  regfile_addr_t [REGFILE_NUM_READ_PORTS-1:0]             raddr;
  logic [REGFILE_NUM_READ_PORTS-1:0][DATA_WIDTH-1:0]      rdata;

  // Fetch to execute
  logic                  op_valid;
  regfile_addr_t         op_rd;
  logic [2:0]            op_funct3;
  logic                  op_sub;
  logic [DATA_WIDTH-1:0] op_a;
  logic [DATA_WIDTH-1:0] op_b;

  // Execute result forwarded to fetch
  logic                  ex_valid;
  regfile_addr_t         ex_rd;
  logic [DATA_WIDTH-1:0] ex_result;

  //--------------------
  // Operand fetch
  //--------------------
  // Writeback is the result port itself
  rf_operand_fetch rf_operand_fetch_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .raddr_o       (raddr),
    .rdata_i       (rdata),
    .ex_valid_i    (ex_valid),
    .ex_rd_i       (ex_rd),
    .ex_result_i   (ex_result),
    .wb_we_i       (result_valid_o),
    .wb_rd_i       (result_rd_o),
    .wb_data_i     (result_o),
    .load_we_i     (load_we_i),
    .load_waddr_i  (load_waddr_i),
    .load_wdata_i  (load_wdata_i),
    .op_valid_o    (op_valid),
    .op_rd_o       (op_rd),
    .op_funct3_o   (op_funct3),
    .op_sub_o      (op_sub),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  //--------------------
  // Register file
  //--------------------
  // Port 1 is the load lane and wins over ALU writeback on port 0
  rf_register_file rf_register_file_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (raddr),
    .rdata_o (rdata),
    .waddr_i ({load_waddr_i, result_rd_o}),
    .wdata_i ({load_wdata_i, result_o}),
    .we_i    ({load_we_i, result_valid_o})
  );

  //--------------------
  // Execute and writeback
  //--------------------
  rf_execute rf_execute_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_valid_i  (op_valid),
    .op_rd_i     (op_rd),
    .op_funct3_i (op_funct3),
    .op_sub_i    (op_sub),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .ex_valid_o  (ex_valid),
    .ex_rd_o     (ex_rd),
    .ex_result_o (ex_result),
    .wb_we_o     (result_valid_o),
    .wb_rd_o     (result_rd_o),
    .wb_data_o   (result_o)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
//--------------------
// Testbench clock source
// Free-running clock with a 4 ns period
//--------------------

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // Low for 2 ns, high for 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: tb_rf_checker.sv
//--------------------
// Result checker for the register-file subsystem
// Keeps a register model in commit order and
// compares every result two cycles after issue
//--------------------

`timescale 1ns/1ns
`default_nettype none

module tb_rf_checker import rf_core_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Stimulus as seen by the DUT
  input  wire logic                  instr_valid_i,
  input  instr_u                     instr_i,
  input  wire logic                  load_we_i,
  input  regfile_addr_t              load_waddr_i,
  input  wire logic [DATA_WIDTH-1:0] load_wdata_i,
  // DUT result port
  input  wire logic                  result_valid_i,
  input  regfile_addr_t              result_rd_i,
  input  wire logic [DATA_WIDTH-1:0] result_i,
  output int                         err_count_o,
  output int                         check_count_o,
  output logic                       idle_o
);

  // Register state after every commit so far
  logic [DATA_WIDTH-1:0] model [REGFILE_NUM_WORDS];

  // Expected results issued one and two cycles back
  logic                  p1_valid = 1'b0;
  regfile_addr_t         p1_rd;
  logic [DATA_WIDTH-1:0] p1_res;
  logic                  p2_valid = 1'b0;
  regfile_addr_t         p2_rd;
  logic [DATA_WIDTH-1:0] p2_res;

  // Prediction for the instruction of this cycle
  logic                  n_valid;
  logic [DATA_WIDTH-1:0] n_res;

  int errors = 0;
  int checks = 0;

  assign err_count_o   = errors;
  assign check_count_o = checks;
  assign idle_o        = !(p1_valid || p2_valid);

  // ALU subset, ADD/SUB only with funct7 zero or 0x20
  function automatic logic is_supported(input instr_u ins);
    logic f3_ok;
    f3_ok = (ins.r_fmt.funct3 == FUNCT3_ADD) || (ins.r_fmt.funct3 == FUNCT3_XOR) ||
            (ins.r_fmt.funct3 == FUNCT3_OR)  || (ins.r_fmt.funct3 == FUNCT3_AND);
    if (ins.r_fmt.opcode == OPCODE_OP) begin
      return f3_ok && ((ins.r_fmt.funct7 == FUNCT7_BASE) ||
             ((ins.r_fmt.funct7 == FUNCT7_SUB) && (ins.r_fmt.funct3 == FUNCT3_ADD)));
    end
    return f3_ok && (ins.i_fmt.opcode == OPCODE_OP_IMM);
  endfunction

  // Committed state plus the ALU result issued one cycle earlier
  // Loads after the issue cycle stay invisible
  function automatic logic [DATA_WIDTH-1:0] read_operand(input regfile_addr_t a);
    if (a == '0) begin
      return '0;
    end
    if (p1_valid && (p1_rd == a)) begin
      return p1_res;
    end
    return model[a];
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expect_result(input instr_u ins);
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] res;
    a = read_operand(ins.r_fmt.rs1);
    if (ins.i_fmt.opcode == OPCODE_OP_IMM) begin
      b = {{(DATA_WIDTH-12){ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    end else begin
      b = read_operand(ins.r_fmt.rs2);
    end
    case (ins.r_fmt.funct3)
      FUNCT3_XOR: res = a ^ b;
      FUNCT3_OR:  res = a | b;
      FUNCT3_AND: res = a & b;
      default: begin
        if ((ins.r_fmt.opcode == OPCODE_OP) && (ins.r_fmt.funct7 == FUNCT7_SUB)) begin
          res = a - b;
        end else begin
          res = a + b;
        end
      end
    endcase
    return res;
  endfunction

  task automatic compare(input string name, input logic [DATA_WIDTH-1:0] exp,
                         input logic [DATA_WIDTH-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %h, got %h at %0t ns", name, exp, got, $time);
    end
  endtask

  //--------------------
  // Per-cycle model
  //--------------------
  // Inputs and outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < REGFILE_NUM_WORDS; r++) begin
        model[r] = '0;
      end
      p1_valid = 1'b0;
      p2_valid = 1'b0;
      compare("result_valid_o", '0, 32'(result_valid_i));
    end else begin
      compare("result_valid_o", 32'(p2_valid), 32'(result_valid_i));
      if (p2_valid && (result_valid_i === 1'b1)) begin
        compare("result_rd_o", 32'(p2_rd), 32'(result_rd_i));
        compare("result_o", p2_res, result_i);
      end
      // Writeback of N-2 and the load of N commit together, load last
      if (p2_valid && (p2_rd != '0)) begin
        model[p2_rd] = p2_res;
      end
      if (load_we_i && (load_waddr_i != '0)) begin
        model[load_waddr_i] = load_wdata_i;
      end
      n_valid = instr_valid_i && is_supported(instr_i);
      if (n_valid) begin
        n_res = expect_result(instr_i);
      end
      p2_valid = p1_valid;
      p2_rd    = p1_rd;
      p2_res   = p1_res;
      p1_valid = n_valid;
      p1_rd    = instr_i.r_fmt.rd;
      p1_res   = n_res;
    end
  end

endmodule

`default_nettype wire

// File: tb_rf_core.sv
//--------------------
// Testbench top for the register-file subsystem
// Directed hazards first, then random instructions and loads
//--------------------

`timescale 1ns/1ns
`default_nettype none

module tb_rf_core import rf_core_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  instr_u                instr;
  logic                  load_we;
  regfile_addr_t         load_waddr;
  logic [DATA_WIDTH-1:0] load_wdata;
  logic                  result_valid;
  regfile_addr_t         result_rd;
  logic [DATA_WIDTH-1:0] result;
  int                    err_count;
  int                    check_count;
  logic                  idle;
  int                    timeouts;
  integer                seed;

  tb_clock_gen tb_clock_gen_i (.clk_o(clk));

  rf_core_top rf_core_top_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .load_we_i      (load_we),
    .load_waddr_i   (load_waddr),
    .load_wdata_i   (load_wdata),
    .result_valid_o (result_valid),
    .result_rd_o    (result_rd),
    .result_o       (result)
  );

  tb_rf_checker tb_rf_checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .load_we_i      (load_we),
    .load_waddr_i   (load_waddr),
    .load_wdata_i   (load_wdata),
    .result_valid_i (result_valid),
    .result_rd_i    (result_rd),
    .result_i       (result),
    .err_count_o    (err_count),
    .check_count_o  (check_count),
    .idle_o         (idle)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input regfile_addr_t rs2,
                                        input regfile_addr_t rs1, input logic [2:0] f3,
                                        input regfile_addr_t rd);
    instr_u u;
    u.r_fmt = '{f7, rs2, rs1, f3, rd, OPCODE_OP};
    return u;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input regfile_addr_t rs1,
                                        input logic [2:0] f3, input regfile_addr_t rd);
    instr_u u;
    u.i_fmt = '{imm, rs1, f3, rd, OPCODE_OP_IMM};
    return u;
  endfunction

  // One cycle of stimulus, launched at the rising edge
  task automatic drive(input logic iv, input logic [31:0] ins, input logic lwe,
                       input regfile_addr_t la, input logic [DATA_WIDTH-1:0] ld);
    @(posedge clk);
    instr_valid <= iv;
    instr       <= ins;
    load_we     <= lwe;
    load_waddr  <= la;
    load_wdata  <= ld;
  endtask

  task automatic issue(input logic [31:0] ins);
    drive(1'b1, ins, 1'b0, 5'd0, '0);
  endtask

  task automatic wait_result();
    int t;
    t = 0;
    @(negedge clk);
    while ((result_valid !== 1'b1) && (t < 8)) begin
      drive(1'b0, '0, 1'b0, 5'd0, '0);
      @(negedge clk);
      t++;
    end
    if (result_valid !== 1'b1) begin
      $display("Timed out waiting for the first result_valid_o");
      timeouts++;
    end
  endtask

  // Idle until no expected result is left in flight
  task automatic wait_drain();
    int t;
    t = 0;
    drive(1'b0, '0, 1'b0, 5'd0, '0);
    while (!idle && (t < 16)) begin
      drive(1'b0, '0, 1'b0, 5'd0, '0);
      t++;
    end
    if (!idle) begin
      $display("Timed out waiting for the pipeline to drain");
      timeouts++;
    end
  endtask

  // Registers x0 to x7 only, so hazards are frequent
  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] ins;
    logic [2:0]  f3;
    r = $random(seed);
    s = $random(seed);
    case (r[1:0])
      2'd0:    f3 = FUNCT3_ADD;
      2'd1:    f3 = FUNCT3_XOR;
      2'd2:    f3 = FUNCT3_OR;
      default: f3 = FUNCT3_AND;
    endcase
    if (r[7:4] < 4'd7) begin
      ins = enc_r((r[8] && (r[1:0] == 2'd0)) ? FUNCT7_SUB : FUNCT7_BASE,
                  {2'b0, r[11:9]}, {2'b0, r[14:12]}, f3, {2'b0, r[17:15]});
    end else if (r[7:4] < 4'd14) begin
      ins = enc_i(r[29:18], {2'b0, r[14:12]}, f3, {2'b0, r[17:15]});
    end else begin
      // Arbitrary word, nearly always an unsupported encoding
      ins = $random(seed);
    end
    drive(s[1:0] != 2'b00, ins, s[3:2] == 2'b00, {2'b0, s[6:4]}, $random(seed));
  endtask

  initial begin
    seed        = 32'h8d9e_8ba5;
    timeouts    = 0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    load_we     = 1'b0;
    load_waddr  = '0;
    load_wdata  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) drive(1'b0, '0, 1'b0, 5'd0, '0);

    // Zero registers right after reset
    issue(enc_i(12'h000, 5'd0, FUNCT3_ADD, 5'd1));
    wait_result();
    issue(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_OR, 5'd3));
    wait_drain();

    // Each operation, SUB and negative immediates
    issue(enc_i(12'h123, 5'd0, FUNCT3_ADD, 5'd1));
    issue(enc_i(12'hffb, 5'd0, FUNCT3_ADD, 5'd2));
    issue(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_ADD, 5'd3));
    issue(enc_r(FUNCT7_SUB, 5'd2, 5'd1, FUNCT3_ADD, 5'd4));
    issue(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_XOR, 5'd5));
    issue(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_OR, 5'd6));
    issue(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_AND, 5'd7));
    issue(enc_i(12'hfff, 5'd1, FUNCT3_XOR, 5'd3));
    issue(enc_i(12'h800, 5'd2, FUNCT3_OR, 5'd4));
    issue(enc_i(12'hf0f, 5'd1, FUNCT3_AND, 5'd5));
    // MUL, a load word and SUB beside XOR are dropped
    issue(enc_r(7'h01, 5'd2, 5'd1, FUNCT3_ADD, 5'd3));
    issue(32'h0000_2083);
    issue(enc_r(FUNCT7_SUB, 5'd2, 5'd1, FUNCT3_XOR, 5'd4));

    // Dependent chain at distance 1, 2 and 3
    issue(enc_i(12'h001, 5'd1, FUNCT3_ADD, 5'd1));
    issue(enc_i(12'h010, 5'd1, FUNCT3_ADD, 5'd2));
    issue(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_ADD, 5'd3));
    issue(enc_r(FUNCT7_SUB, 5'd3, 5'd1, FUNCT3_ADD, 5'd4));

    // Load in the writeback cycle of x6 wins, later ALU write overwrites the load
    issue(enc_i(12'h007, 5'd0, FUNCT3_ADD, 5'd6));
    drive(1'b0, '0, 1'b0, 5'd0, '0);
    drive(1'b1, enc_r(FUNCT7_BASE, 5'd0, 5'd6, FUNCT3_ADD, 5'd7), 1'b1, 5'd6, 32'hdead_beef);
    issue(enc_r(FUNCT7_BASE, 5'd0, 5'd6, FUNCT3_ADD, 5'd7));
    drive(1'b1, enc_i(12'h001, 5'd6, FUNCT3_ADD, 5'd6), 1'b1, 5'd6, 32'h1111_1111);
    drive(1'b0, '0, 1'b0, 5'd0, '0);
    issue(enc_r(FUNCT7_BASE, 5'd0, 5'd6, FUNCT3_ADD, 5'd7));

    // Writes to x0 from both ports
    drive(1'b1, enc_i(12'h055, 5'd0, FUNCT3_ADD, 5'd0), 1'b1, 5'd0, 32'hffff_ffff);
    issue(enc_r(FUNCT7_BASE, 5'd0, 5'd0, FUNCT3_OR, 5'd1));
    issue(enc_r(FUNCT7_BASE, 5'd0, 5'd0, FUNCT3_ADD, 5'd2));
    wait_drain();

    repeat (3000) drive_random();
    wait_drain();

    $display("Checks: %0d, value errors: %0d, timeouts: %0d", check_count, err_count, timeouts);
    if ((err_count == 0) && (timeouts == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rf_core.f
rf_core_pkg.sv
rf_register_file.sv
rf_operand_fetch.sv
rf_execute.sv
rf_core_top.sv
tb_clock_gen.sv
tb_rf_checker.sv
tb_rf_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register-file subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_rf_core -f rf_core.f -o tb_rf_core

out=$(./obj_dir/tb_rf_core)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi
